// ==== src/simd_pkg.sv ====
/*
 * Shared SIMD definitions: operation and element width encodings,
 * register address width, latency type and the queued command layout
 */
`default_nettype none

package simd_pkg;

    // Operation codes carried on the command port
    typedef enum logic [2:0] {
        VADD    = 3'd0,
        VSUB    = 3'd1,  // vs2 - vs1
        VAND    = 3'd2,
        VOR     = 3'd3,
        VXOR    = 3'd4,
        VMUL    = 3'd5,  // Low half of product
        VMACC   = 3'd6,  // vd + vs1 * vs2
        VREDSUM = 3'd7   // vs1[0] + sum(vs2)
    } simd_op_t;

    // Element width
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_t;

    // Vector register file addressing
    localparam int VREG_AW   = 3;
    localparam int NUM_VREGS = 1 << VREG_AW;

    // Execution latency in cycles
    localparam int LAT_W = 4;
    typedef logic [LAT_W-1:0] lat_t;

    // One entry of the issue queue
    typedef struct packed {
        simd_op_t           op;
        sew_t               sew;
        logic [VREG_AW-1:0] vd;
        logic [VREG_AW-1:0] vs1;
        logic [VREG_AW-1:0] vs2;
    } simd_cmd_t;

endpackage

`default_nettype wire

// ==== src/simd_issue_queue.sv ====
/*
 * Issue queue: circular FIFO of accepted SIMD commands,
 * head popped on issue and cleared on flush
 */
`timescale 1ns/1ns
`default_nettype none

module simd_issue_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,
    input  logic                              flush_i,

    input  logic                              cmd_valid_i,
    input  simd_pkg::simd_op_t                cmd_op_i,
    input  simd_pkg::sew_t                    cmd_sew_i,
    input  logic [simd_pkg::VREG_AW-1:0]      cmd_vd_i,
    input  logic [simd_pkg::VREG_AW-1:0]      cmd_vs1_i,
    input  logic [simd_pkg::VREG_AW-1:0]      cmd_vs2_i,
    output logic                              cmd_ready_o,

    input  logic                              pop_i,
    output logic                              head_valid_o,
    output simd_pkg::simd_op_t                head_op_o,
    output simd_pkg::sew_t                    head_sew_o,
    output logic [simd_pkg::VREG_AW-1:0]      head_vd_o,
    output logic [simd_pkg::VREG_AW-1:0]      head_vs1_o,
    output logic [simd_pkg::VREG_AW-1:0]      head_vs2_o
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    simd_pkg::simd_cmd_t mem [QUEUE_DEPTH];
    simd_pkg::simd_cmd_t cmd_in;
    simd_pkg::simd_cmd_t head;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign cmd_ready_o  = (count != CNT_W'(QUEUE_DEPTH));  // Low only when full
    assign head_valid_o = (count != '0);

    // A transfer during flush is dropped along with the queue contents
    assign push = cmd_valid_i & cmd_ready_o & ~flush_i;
    assign pop  = pop_i & head_valid_o;

    assign cmd_in = '{op: cmd_op_i, sew: cmd_sew_i, vd: cmd_vd_i,
                      vs1: cmd_vs1_i, vs2: cmd_vs2_i};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr] <= cmd_in;
        end
    end

    assign head       = mem[rd_ptr];
    assign head_op_o  = head.op;
    assign head_sew_o = head.sew;
    assign head_vd_o  = head.vd;
    assign head_vs1_o = head.vs1;
    assign head_vs2_o = head.vs2;

endmodule

`default_nettype wire

// ==== src/simd_score_board.sv ====
/*
 * Write-back scoreboard: latency decode, one valid shift lane per
 * latency and the stall/issue decision for the queue head
 */
`timescale 1ns/1ns
`default_nettype none

module simd_score_board #(
    parameter int VLEN = 64
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           flush_i,

    input  logic                           ready_i,      // Queue head valid
    input  simd_pkg::simd_op_t             op_i,
    input  simd_pkg::sew_t                 sew_i,

    output logic                           issue_fire_o,
    output simd_pkg::lat_t                 issue_lat_o,
    output logic [$clog2(VLEN/8):0]        lane_done_o   // Bit L-1 for latency L
);

    localparam int MAX_STAGES = $clog2(VLEN / 8) + 1;
    localparam int RED_BASE   = $clog2(VLEN / 8);   // Reduction tree depth at SEW 32

    simd_pkg::lat_t        lat;
    logic                  issue_fire;
    logic                  done_1;
    logic [MAX_STAGES-1:0] lane_last;
    logic [MAX_STAGES-1:1] conflict;  // Bit K-1 from the latency-K lane

    // Latency by operation and element width
    always_comb begin
        case (op_i)
            simd_pkg::VMUL: begin
                lat = (sew_i == simd_pkg::SEW_64) ? simd_pkg::lat_t'(3) : simd_pkg::lat_t'(2);
            end
            simd_pkg::VMACC: begin
                lat = (sew_i == simd_pkg::SEW_64) ? simd_pkg::lat_t'(4) : simd_pkg::lat_t'(3);
            end
            simd_pkg::VREDSUM: begin
                // Narrow elements need a deeper adder tree
                case (sew_i)
                    simd_pkg::SEW_8,
                    simd_pkg::SEW_16: lat = simd_pkg::lat_t'(RED_BASE + 1);
                    simd_pkg::SEW_32: lat = simd_pkg::lat_t'(RED_BASE);
                    default:          lat = simd_pkg::lat_t'(RED_BASE - 1);
                endcase
            end
            default: lat = simd_pkg::lat_t'(1);  // Plain element-wise ops
        endcase
    end

    // Single-cycle commands finish through one registered bit
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            done_1 <= 1'b0;
        end else begin
            done_1 <= issue_fire & (lat == simd_pkg::lat_t'(1));
        end
    end

    assign lane_last[0] = done_1;

    for (genvar k = 2; k <= MAX_STAGES; k++) begin : g_lane
        logic [k-1:0] vbits;  // Index j set j cycles after issue
        logic         hit;

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                vbits <= '0;
            end else if (flush_i) begin
                vbits <= '0;
            end else begin
                vbits <= {vbits[k-2:0], issue_fire & (lat == simd_pkg::lat_t'(k))};
            end
        end

        // An older K command at stage K-L-1 would finish with a new L command
        always_comb begin
            hit = 1'b0;
            for (int j = 0; j <= k - 2; j++) begin
                if (lat == simd_pkg::lat_t'(k - 1 - j)) begin
                    hit = hit | vbits[j];
                end
            end
        end

        assign conflict[k-1]  = hit;
        assign lane_last[k-1] = vbits[k-1];
    end

    assign issue_fire   = ready_i & ~(|conflict) & ~flush_i;
    assign issue_fire_o = issue_fire;
    assign issue_lat_o  = lat;

    // Completions in a flush cycle are discarded too
    assign lane_done_o = lane_last & {MAX_STAGES{~flush_i}};

endmodule

`default_nettype wire

// ==== src/simd_vreg_file.sv ====
/*
 * Vector register file: three asynchronous read ports and one
 * write port shared by write-back and host preload
 */
`timescale 1ns/1ns
`default_nettype none

module simd_vreg_file #(
    parameter int VLEN = 64
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    input  logic [simd_pkg::VREG_AW-1:0] rs1_addr_i,
    input  logic [simd_pkg::VREG_AW-1:0] rs2_addr_i,
    input  logic [simd_pkg::VREG_AW-1:0] rd_addr_i,
    output logic [VLEN-1:0]              rs1_data_o,
    output logic [VLEN-1:0]              rs2_data_o,
    output logic [VLEN-1:0]              rd_data_o,   // Old vd value for VMACC

    input  logic                         wb_we_i,
    input  logic [simd_pkg::VREG_AW-1:0] wb_addr_i,
    input  logic [VLEN-1:0]              wb_data_i,
    input  logic                         host_we_i,
    input  logic [simd_pkg::VREG_AW-1:0] host_addr_i,
    input  logic [VLEN-1:0]              host_data_i
);

    logic [VLEN-1:0] regs [simd_pkg::NUM_VREGS];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < simd_pkg::NUM_VREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we_i) begin
            regs[wb_addr_i] <= wb_data_i;  // Host write lost this cycle
        end else if (host_we_i) begin
            regs[host_addr_i] <= host_data_i;
        end
    end

    // Committed state only, no bypass from write-back
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];
    assign rd_data_o  = regs[rd_addr_i];

endmodule

`default_nettype wire

// ==== src/simd_exec_pipe.sv ====
/*
 * SIMD execution: per-SEW element arithmetic and reduction at issue,
 * result delay lanes per latency, write-back selection
 */
`timescale 1ns/1ns
`default_nettype none

module simd_exec_pipe #(
    parameter int VLEN = 64
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,

    input  logic                         issue_fire_i,
    input  simd_pkg::lat_t               issue_lat_i,
    input  simd_pkg::simd_op_t           op_i,
    input  simd_pkg::sew_t               sew_i,
    input  logic [simd_pkg::VREG_AW-1:0] vd_i,
    input  logic [VLEN-1:0]              vs1_data_i,
    input  logic [VLEN-1:0]              vs2_data_i,
    input  logic [VLEN-1:0]              vd_data_i,
    input  logic [$clog2(VLEN/8):0]      lane_done_i,

    output logic                         wb_valid_o,
    output logic [simd_pkg::VREG_AW-1:0] wb_vd_o,
    output logic [VLEN-1:0]              wb_data_o
);

    localparam int MAX_STAGES = $clog2(VLEN / 8) + 1;

    logic [VLEN-1:0]              elem_res  [4];  // Indexed by SEW
    logic [VLEN-1:0]              red_res   [4];
    logic [VLEN-1:0]              result;
    logic [VLEN-1:0]              last_data [MAX_STAGES];
    logic [simd_pkg::VREG_AW-1:0] last_vd   [MAX_STAGES];

    // One element; callers keep the low EW bits, which is modular arithmetic
    function automatic logic [63:0] elem_op(input simd_pkg::simd_op_t op,
                                            input logic [63:0] a,
                                            input logic [63:0] b,
                                            input logic [63:0] c);
        case (op)
            simd_pkg::VADD:  return b + a;
            simd_pkg::VSUB:  return b - a;
            simd_pkg::VAND:  return b & a;
            simd_pkg::VOR:   return b | a;
            simd_pkg::VXOR:  return b ^ a;
            simd_pkg::VMUL:  return a * b;
            simd_pkg::VMACC: return c + a * b;
            default:         return '0;  // Reduction handled separately
        endcase
    endfunction

    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int EW = 8 << s;
        localparam int NE = VLEN / EW;

        always_comb begin
            logic [63:0]   tmp;
            logic [EW-1:0] acc;
            acc = vs1_data_i[EW-1:0];  // Seed with vs1 element 0
            for (int i = 0; i < NE; i++) begin
                tmp = elem_op(op_i, 64'(vs1_data_i[i*EW +: EW]),
                              64'(vs2_data_i[i*EW +: EW]), 64'(vd_data_i[i*EW +: EW]));
                elem_res[s][i*EW +: EW] = tmp[EW-1:0];
                acc = acc + vs2_data_i[i*EW +: EW];
            end
            red_res[s]         = '0;
            red_res[s][EW-1:0] = acc;
        end
    end

    assign result = (op_i == simd_pkg::VREDSUM) ? red_res[sew_i] : elem_res[sew_i];

    // Lane l is l stages deep, entered only by latency-l commands
    for (genvar l = 1; l <= MAX_STAGES; l++) begin : g_lane
        logic [VLEN-1:0]              data_q [l];
        logic [simd_pkg::VREG_AW-1:0] vd_q   [l];

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                for (int j = 0; j < l; j++) begin
                    data_q[j] <= '0;
                    vd_q[j]   <= '0;
                end
            end else begin
                if (issue_fire_i && (issue_lat_i == simd_pkg::lat_t'(l))) begin
                    data_q[0] <= result;
                    vd_q[0]   <= vd_i;
                end
                for (int j = 1; j < l; j++) begin
                    data_q[j] <= data_q[j-1];
                    vd_q[j]   <= vd_q[j-1];
                end
            end
        end

        assign last_data[l-1] = data_q[l-1];
        assign last_vd[l-1]   = vd_q[l-1];
    end

    // Scoreboard guarantees a single done bit
    always_comb begin
        wb_data_o = '0;
        wb_vd_o   = '0;
        for (int l = 0; l < MAX_STAGES; l++) begin
            if (lane_done_i[l]) begin
                wb_data_o = last_data[l];
                wb_vd_o   = last_vd[l];
            end
        end
    end

    assign wb_valid_o = |lane_done_i;

endmodule

`default_nettype wire

// ==== src/simd_unit_top.sv ====
/*
 * SIMD unit top level: issue queue, scoreboard, register file and execution pipe
 */
`timescale 1ns/1ns
`default_nettype none

module simd_unit_top #(
    parameter int VLEN        = 64,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                         clk_i,
    input  logic                         rstn_i,
    input  logic                         flush_i,

    input  logic                         cmd_valid_i,
    output logic                         cmd_ready_o,
    input  simd_pkg::simd_op_t           cmd_op_i,
    input  simd_pkg::sew_t               cmd_sew_i,
    input  logic [simd_pkg::VREG_AW-1:0] cmd_vd_i,
    input  logic [simd_pkg::VREG_AW-1:0] cmd_vs1_i,
    input  logic [simd_pkg::VREG_AW-1:0] cmd_vs2_i,

    input  logic                         host_we_i,    // Preload while idle
    input  logic [simd_pkg::VREG_AW-1:0] host_addr_i,
    input  logic [VLEN-1:0]              host_data_i,

    output logic                         wb_valid_o,
    output logic [simd_pkg::VREG_AW-1:0] wb_vd_o,
    output logic [VLEN-1:0]              wb_data_o
);

    localparam int MAX_STAGES = $clog2(VLEN / 8) + 1;

    logic                         q_valid;
    simd_pkg::simd_op_t           q_op;
    simd_pkg::sew_t               q_sew;
    logic [simd_pkg::VREG_AW-1:0] q_vd;
    logic [simd_pkg::VREG_AW-1:0] q_vs1;
    logic [simd_pkg::VREG_AW-1:0] q_vs2;
    logic                         issue_fire;
    simd_pkg::lat_t               issue_lat;
    logic [MAX_STAGES-1:0]        lane_done;
    logic [VLEN-1:0]              vs1_data;
    logic [VLEN-1:0]              vs2_data;
    logic [VLEN-1:0]              vd_data;

    simd_issue_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) issue_queue0 (
        .clk_i, .rstn_i, .flush_i,
        .cmd_valid_i, .cmd_op_i, .cmd_sew_i, .cmd_vd_i, .cmd_vs1_i, .cmd_vs2_i,
        .cmd_ready_o,
        .pop_i(issue_fire),
        .head_valid_o(q_valid), .head_op_o(q_op), .head_sew_o(q_sew),
        .head_vd_o(q_vd), .head_vs1_o(q_vs1), .head_vs2_o(q_vs2)
    );

    simd_score_board #(.VLEN(VLEN)) score_board0 (
        .clk_i, .rstn_i, .flush_i,
        .ready_i(q_valid), .op_i(q_op), .sew_i(q_sew),
        .issue_fire_o(issue_fire), .issue_lat_o(issue_lat), .lane_done_o(lane_done)
    );

    // Write-back port doubles as the register file write port
    simd_vreg_file #(.VLEN(VLEN)) vreg_file0 (
        .clk_i, .rstn_i,
        .rs1_addr_i(q_vs1), .rs2_addr_i(q_vs2), .rd_addr_i(q_vd),
        .rs1_data_o(vs1_data), .rs2_data_o(vs2_data), .rd_data_o(vd_data),
        .wb_we_i(wb_valid_o), .wb_addr_i(wb_vd_o), .wb_data_i(wb_data_o),
        .host_we_i, .host_addr_i, .host_data_i
    );

    simd_exec_pipe #(.VLEN(VLEN)) exec_pipe0 (
        .clk_i, .rstn_i,
        .issue_fire_i(issue_fire), .issue_lat_i(issue_lat),
        .op_i(q_op), .sew_i(q_sew), .vd_i(q_vd),
        .vs1_data_i(vs1_data), .vs2_data_i(vs2_data), .vd_data_i(vd_data),
        .lane_done_i(lane_done),
        .wb_valid_o, .wb_vd_o, .wb_data_o
    );

endmodule

`default_nettype wire

// ==== verification/simd_ref_model.svh ====
/*
 * Reference model for the SIMD unit testbench: latency and result per command
 */
`ifndef SIMD_REF_MODEL_SVH
`define SIMD_REF_MODEL_SVH

// Cycles from issue to the register file write, VLEN of 64
function automatic int latency_of(input simd_pkg::simd_op_t op, input simd_pkg::sew_t sew);
    int lat;
    case (op)
        simd_pkg::VMUL:    lat = (sew == simd_pkg::SEW_64) ? 3 : 2;
        simd_pkg::VMACC:   lat = (sew == simd_pkg::SEW_64) ? 4 : 3;
        simd_pkg::VREDSUM: begin
            if (sew == simd_pkg::SEW_64) begin
                lat = 2;
            end else if (sew == simd_pkg::SEW_32) begin
                lat = 3;
            end else begin
                lat = 4;  // SEW 8 and 16
            end
        end
        default:           lat = 1;
    endcase
    return lat;
endfunction

// Expected write-back value for one command
function automatic logic [63:0] result_of(input simd_pkg::simd_op_t op,
                                          input simd_pkg::sew_t sew,
                                          input logic [63:0] vs1,
                                          input logic [63:0] vs2,
                                          input logic [63:0] vd);
    int          ew;
    int          i;
    logic [63:0] mask;
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] z;
    logic [63:0] r;
    logic [63:0] sum;
    logic [63:0] res;
    ew   = 8 << sew;
    mask = (ew == 64) ? '1 : (64'd1 << ew) - 64'd1;
    sum  = vs1 & mask;  // Element 0 of vs1
    res  = '0;
    for (i = 0; i < 64 / ew; i++) begin
        x = (vs1 >> (i * ew)) & mask;
        y = (vs2 >> (i * ew)) & mask;
        z = (vd >> (i * ew)) & mask;
        case (op)
            simd_pkg::VADD:  r = y + x;
            simd_pkg::VSUB:  r = y - x;
            simd_pkg::VAND:  r = y & x;
            simd_pkg::VOR:   r = y | x;
            simd_pkg::VXOR:  r = y ^ x;
            simd_pkg::VMUL:  r = x * y;
            simd_pkg::VMACC: r = z + x * y;
            default:         r = '0;
        endcase
        sum = sum + y;
        res = res | ((r & mask) << (i * ew));
    end
    if (op == simd_pkg::VREDSUM) begin
        res = sum & mask;  // Upper elements zero
    end
    return res;
endfunction

`endif

// ==== verification/tb_simd_unit.sv ====
/*
 * Testbench for the SIMD unit: per-op checks, mixed latencies, stalls,
 * full queue and flush, with write-backs checked against the reference model
 */
`timescale 1ns/1ns
`default_nettype none

module tb_simd_unit;

    localparam int VLEN        = 64;
    localparam int QUEUE_DEPTH = 4;
    localparam int TIMEOUT     = 200;  // Cycles allowed per wait

    `include "simd_ref_model.svh"

    typedef struct {
        logic [simd_pkg::VREG_AW-1:0] vd;
        logic [63:0]                  data;
        int                           lat;
        int                           acc;    // Edge where the command was accepted
        int                           delay;  // Accept to write edge, 0 if unchecked
    } exp_t;

    logic                         clk_i;
    logic                         rstn_i;
    logic                         flush_i;
    logic                         cmd_valid_i;
    logic                         cmd_ready_o;
    simd_pkg::simd_op_t           cmd_op_i;
    simd_pkg::sew_t               cmd_sew_i;
    logic [simd_pkg::VREG_AW-1:0] cmd_vd_i;
    logic [simd_pkg::VREG_AW-1:0] cmd_vs1_i;
    logic [simd_pkg::VREG_AW-1:0] cmd_vs2_i;
    logic                         host_we_i;
    logic [simd_pkg::VREG_AW-1:0] host_addr_i;
    logic [VLEN-1:0]              host_data_i;
    logic                         wb_valid_o;
    logic [simd_pkg::VREG_AW-1:0] wb_vd_o;
    logic [VLEN-1:0]              wb_data_o;

    exp_t        pending [$];
    logic [63:0] shadow [8];  // Committed register contents
    int          cyc = 0;
    int          errors;
    int          seed;
    logic        aborted;
    logic        ready_dropped;

    simd_unit_top #(.VLEN(VLEN), .QUEUE_DEPTH(QUEUE_DEPTH)) dut0 (
        .clk_i, .rstn_i, .flush_i,
        .cmd_valid_i, .cmd_ready_o, .cmd_op_i, .cmd_sew_i, .cmd_vd_i, .cmd_vs1_i, .cmd_vs2_i,
        .host_we_i, .host_addr_i, .host_data_i,
        .wb_valid_o, .wb_vd_o, .wb_data_o
    );

    always #50 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        errors++;
        $display("ERROR %s expected %h got %h", name, exp, got);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic preload_random();
        int r;
        for (r = 0; r < 8; r++) begin
            host_we_i   = 1'b1;
            host_addr_i = 3'(r);
            host_data_i = {$random(seed), $random(seed)};
            @(posedge clk_i);
            #1;
            shadow[r] = host_data_i;
        end
        host_we_i = 1'b0;
    endtask

    // Extra counts stall cycles beyond latency plus one and negative skips the timing check
    task automatic send_cmd(input simd_pkg::simd_op_t op, input simd_pkg::sew_t sew,
                            input logic [2:0] vd, input logic [2:0] vs1,
                            input logic [2:0] vs2, input int extra);
        exp_t e;
        int   n;
        logic accepted;
        e.vd        = vd;
        e.data      = result_of(op, sew, shadow[vs1], shadow[vs2], shadow[vd]);
        e.lat       = latency_of(op, sew);
        e.delay     = (extra < 0) ? 0 : e.lat + 1 + extra;
        cmd_valid_i = 1'b1;
        cmd_op_i    = op;
        cmd_sew_i   = sew;
        cmd_vd_i    = vd;
        cmd_vs1_i   = vs1;
        cmd_vs2_i   = vs2;
        accepted    = 1'b0;
        n           = 0;
        while (!accepted && !aborted) begin
            @(negedge clk_i);
            accepted = cmd_ready_o;  // Ready is stable between edges
            @(posedge clk_i);
            #1;
            n++;
            if (!accepted && n >= TIMEOUT) begin
                report_failure("Timeout: command was never accepted");
                aborted = 1'b1;
            end
        end
        if (accepted) begin
            e.acc = cyc;
            pending.push_back(e);
        end
        cmd_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending.size() != 0 && !aborted) begin
            @(posedge clk_i);
            #1;
            n++;
            if (n >= TIMEOUT) begin
                report_failure($sformatf("Timeout: %0d results never written back",
                                         pending.size()));
                aborted = 1'b1;
            end
        end
    endtask

    // Oldest matching entry, or the oldest for this register when the data is wrong
    task automatic check_wb();
        int idx;
        int i;
        idx = -1;
        for (i = pending.size() - 1; i >= 0; i--) begin
            if (pending[i].vd == wb_vd_o && pending[i].data == wb_data_o) idx = i;
        end
        if (idx < 0) begin
            for (i = pending.size() - 1; i >= 0; i--) begin
                if (pending[i].vd == wb_vd_o) idx = i;
            end
        end
        assert (idx >= 0)
            else report_failure($sformatf("Write-back to v%0d with no command outstanding",
                                          wb_vd_o));
        if (idx >= 0) begin
            assert (wb_data_o == pending[idx].data)
                else report_mismatch("wb_data_o", pending[idx].data, wb_data_o);
            for (i = 0; i < idx; i++) begin
                assert (pending[i].lat != pending[idx].lat)
                    else report_failure("Write-back overtook an older command of equal latency");
            end
            assert (pending[idx].delay == 0 || cyc + 1 - pending[idx].acc == pending[idx].delay)
                else report_mismatch("wb_valid_o delay", 64'(pending[idx].delay),
                                     64'(cyc + 1 - pending[idx].acc));
            pending.delete(idx);
        end
        shadow[wb_vd_o] = wb_data_o;
    endtask

    // Outputs sampled mid-cycle
    always @(negedge clk_i) begin
        if (rstn_i) begin
            if (!cmd_ready_o) ready_dropped = 1'b1;
            if (wb_valid_o) check_wb();
        end
    end

    task automatic stall_pair(input simd_pkg::simd_op_t op_a, input simd_pkg::sew_t sew_a,
                              input simd_pkg::simd_op_t op_b, input simd_pkg::sew_t sew_b);
        send_cmd(op_a, sew_a, 3'd4, 3'd0, 3'd1, 0);
        idle_cycles(latency_of(op_a, sew_a) - latency_of(op_b, sew_b) - 1);
        send_cmd(op_b, sew_b, 3'd5, 3'd2, 3'd3, 1);  // One stall cycle expected
        wait_drain();
    endtask

    // Latencies 4, 3, 2, 1 in turn, which stalls every other issue
    task automatic send_stall_group(input int base);
        int k;
        for (k = 0; k < 4; k++) begin
            send_cmd((k == 0) ? simd_pkg::VREDSUM : ((k == 3) ? simd_pkg::VADD : simd_pkg::VMUL),
                     (k == 1) ? simd_pkg::SEW_64 : simd_pkg::SEW_8,
                     3'(4 + k), 3'(base + k), 3'(k), -1);
        end
    endtask

    initial begin
        int                           o;
        logic [simd_pkg::VREG_AW-1:0] rd;
        logic [simd_pkg::VREG_AW-1:0] ra;
        logic [simd_pkg::VREG_AW-1:0] rb;
        clk_i         = 1'b0;
        rstn_i        = 1'b0;
        flush_i       = 1'b0;
        cmd_valid_i   = 1'b0;
        cmd_op_i      = simd_pkg::VADD;
        cmd_sew_i     = simd_pkg::SEW_8;
        cmd_vd_i      = '0;
        cmd_vs1_i     = '0;
        cmd_vs2_i     = '0;
        host_we_i     = 1'b0;
        host_addr_i   = '0;
        host_data_i   = '0;
        errors        = 0;
        seed          = 51;
        aborted       = 1'b0;
        ready_dropped = 1'b0;
        for (o = 0; o < 8; o++) begin
            shadow[o] = '0;
        end
        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // Idle state after reset
        @(negedge clk_i);
        assert (wb_valid_o == 1'b0) else report_mismatch("wb_valid_o", 64'd0, 64'(wb_valid_o));
        assert (cmd_ready_o == 1'b1) else report_mismatch("cmd_ready_o", 64'd1, 64'(cmd_ready_o));
        @(posedge clk_i);
        #1;

        // Every op at every SEW, one command at a time
        for (o = 0; o < 32; o++) begin
            if (o % 4 == 0) preload_random();
            rd = 3'($random(seed));
            ra = 3'($random(seed));
            rb = 3'($random(seed));
            send_cmd(simd_pkg::simd_op_t'(3'(o / 4)), simd_pkg::sew_t'(2'(o)), rd, ra, rb, 0);
            wait_drain();
        end

        // Back-to-back mixed latencies, sources v0-v3 and destinations v4-v7
        preload_random();
        for (o = 0; o < 12; o++) begin
            rd = 3'(4 + ($unsigned($random(seed)) % 4));
            ra = 3'($unsigned($random(seed)) % 4);
            rb = 3'($unsigned($random(seed)) % 4);
            send_cmd(simd_pkg::simd_op_t'((($unsigned($random(seed)) % 7) == 6) ? 3'd7 :
                                          3'($unsigned($random(seed)) % 6)),
                     simd_pkg::sew_t'(2'($random(seed))), rd, ra, rb, -1);
        end
        wait_drain();

        // Short command lands on the completion cycle of a longer one
        stall_pair(simd_pkg::VMACC, simd_pkg::SEW_64, simd_pkg::VADD, simd_pkg::SEW_32);
        stall_pair(simd_pkg::VMACC, simd_pkg::SEW_32, simd_pkg::VMUL, simd_pkg::SEW_8);
        stall_pair(simd_pkg::VREDSUM, simd_pkg::SEW_16, simd_pkg::VMUL, simd_pkg::SEW_16);
        stall_pair(simd_pkg::VMUL, simd_pkg::SEW_32, simd_pkg::VXOR, simd_pkg::SEW_8);

        // Fill the queue behind stalls
        ready_dropped = 1'b0;
        for (o = 0; o < 4; o++) begin
            send_stall_group(0);
        end
        wait_drain();
        assert (ready_dropped) else report_mismatch("cmd_ready_o", 64'd0, 64'd1);

        // Flush with work queued and in flight
        send_stall_group(0);
        flush_i = 1'b1;
        pending.delete();  // Nothing may come out after this
        idle_cycles(1);
        flush_i = 1'b0;
        idle_cycles(8);
        assert (cmd_ready_o == 1'b1) else report_mismatch("cmd_ready_o", 64'd1, 64'(cmd_ready_o));
        send_cmd(simd_pkg::VADD, simd_pkg::SEW_16, 3'd4, 3'd0, 3'd1, -1);
        send_cmd(simd_pkg::VMUL, simd_pkg::SEW_32, 3'd5, 3'd2, 3'd3, -1);
        send_cmd(simd_pkg::VREDSUM, simd_pkg::SEW_8, 3'd6, 3'd1, 3'd2, -1);
        wait_drain();
        idle_cycles(4);

        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+verification
src/simd_pkg.sv
src/simd_issue_queue.sv
src/simd_score_board.sv
src/simd_vreg_file.sv
src/simd_exec_pipe.sv
src/simd_unit_top.sv
verification/tb_simd_unit.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the SIMD unit testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
set -o pipefail
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module tb_simd_unit \
    -o tb_simd_unit \
    && ./obj_dir/tb_simd_unit | tee sim.log \
    || { echo "Build or simulation error"; exit 1; }
! grep -q "SOME TESTS FAILED" sim.log && grep -q "ALL TESTS PASSED" sim.log \
    && echo "Result: pass" \
    || { echo "Result: fail"; exit 1; }
